// File: build.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/decode_stage_reg.sv
logic/instr_classifier.sv
logic/imm_gen.sv
logic/alu_ctrl_gen.sv
logic/rv_decode_top.sv
test/rv_decode_assert.sv
test/tb_rv_decode.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --timing --assert --timescale 1ns/1ps
TOP        := tb_rv_decode
FILELIST   := build.f
OBJ_DIR    := obj_dir
PASS_MSG   := ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_rv_decode.sv
`default_nettype none

`include "rv_decode_defs.svh"

module tb_rv_decode
    import rv_decode_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // instruction class the stimulus was built as
    typedef enum
    {
        K_NONE, K_LOAD, K_STORE, K_IMM, K_REG,
        K_LUI, K_AUIPC, K_BRANCH, K_JAL, K_JALR
    } kind_sel_t;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_stall;
    logic                   i_flush;
    logic                   i_ready;
    logic [`RV_INSTR_W-1:0] i_instruction;
    logic [`RV_XLEN-1:0]    i_pc;
    logic [`RV_XLEN-1:0]    o_pc;
    logic [`RV_XLEN-1:0]    o_pc_next;
    logic [`RV_REG_W-1:0]   o_rs1;
    logic [`RV_REG_W-1:0]   o_rs2;
    logic [`RV_REG_W-1:0]   o_rd;
    logic [`RV_XLEN-1:0]    o_imm_i;
    logic [`RV_XLEN-1:0]    o_imm_j;
    alu_res_t               o_alu_res;
    alu_ctrl_t              o_alu_ctrl;
    logic [`RV_FUNCT3_W-1:0] o_funct3;
    res_src_t               o_res_src;
    src_op1_t               o_op1_src;
    src_op2_t               o_op2_src;
    logic                   o_reg_write;
    logic                   o_inst_jal;
    logic                   o_inst_jalr;
    logic                   o_inst_branch;
    logic                   o_inst_store;
    logic                   o_inst_supported;

    // expected decode of the word in the register
    kind_sel_t              e_kind;
    alu_op_t                e_op;
    logic [4:0]             e_rs1;
    logic [4:0]             e_rs2;
    logic [4:0]             e_rd;
    logic [2:0]             e_funct3;
    logic [31:0]            e_pc;
    logic [31:0]            e_imm_i;
    logic [31:0]            e_imm_j;
    logic                   e_sup;
    logic                   chk_imm_i;
    logic                   chk_imm_j;

    rv_decode_top dut
    (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_stall          (i_stall),
        .i_flush          (i_flush),
        .i_ready          (i_ready),
        .i_instruction    (i_instruction),
        .i_pc             (i_pc),
        .o_pc             (o_pc),
        .o_pc_next        (o_pc_next),
        .o_rs1            (o_rs1),
        .o_rs2            (o_rs2),
        .o_rd             (o_rd),
        .o_imm_i          (o_imm_i),
        .o_imm_j          (o_imm_j),
        .o_alu_res        (o_alu_res),
        .o_alu_ctrl       (o_alu_ctrl),
        .o_funct3         (o_funct3),
        .o_res_src        (o_res_src),
        .o_op1_src        (o_op1_src),
        .o_op2_src        (o_op2_src),
        .o_reg_write      (o_reg_write),
        .o_inst_jal       (o_inst_jal),
        .o_inst_jalr      (o_inst_jalr),
        .o_inst_branch    (o_inst_branch),
        .o_inst_store     (o_inst_store),
        .o_inst_supported (o_inst_supported)
    );

    always #10 i_clk = ~i_clk;

    function automatic logic [4:0] rand_reg();
        return 5'($urandom());
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $urandom();
        return {r[31:2], 2'b00};
    endfunction

    // funct3 table of the register and immediate ALU group
    function automatic alu_op_t op_for(input logic [2:0] f3, input logic alt);
        alu_op_t ops [8];
        ops = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
        if (alt && f3 == 3'd0)
            return SUB;
        if (alt && f3 == 3'd5)
            return SRA;
        return ops[f3];
    endfunction

    function automatic alu_res_t expected_res(input alu_op_t op);
        alu_res_t res;
        res.cmp   = op inside {SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU};
        res.bits  = op inside {AND, OR, XOR};
        res.shift = op inside {SLL, SRL, SRA};
        res.arith = op inside {ADD, SUB};
        return res;
    endfunction

    function automatic alu_ctrl_t expected_ctrl(input alu_op_t op);
        alu_ctrl_t c;
        c.cmp_eq             = op inside {BEQ, BNE};
        c.cmp_lts            = op inside {SLT, BLT, BGE};
        c.cmp_ltu            = op inside {SLTU, BLTU, BGEU};
        c.cmp_inversed       = op inside {BNE, BGE, BGEU};
        c.bits_and           = (op == AND);
        c.bits_or            = (op == OR);
        c.bits_xor           = (op == XOR);
        c.arith_shl          = (op == SLL);
        c.arith_shr          = op inside {SRL, SRA};
        c.arith_sub          = (op == SUB);
        c.arith_add          = (op == ADD);
        c.shift_arithmetical = (op == SRA);
        return c;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // drive on the rising edge, let it be captured, sample mid-cycle
    task automatic present(input logic [31:0] word, input logic [31:0] pc,
                           input logic stall = 1'b0, input logic flush = 1'b0,
                           input logic ready = 1'b1);
        @(posedge i_clk);
        i_instruction <= word;
        i_pc          <= pc;
        i_stall       <= stall;
        i_flush       <= flush;
        i_ready       <= ready;
        @(posedge i_clk);
        @(negedge i_clk);
    endtask

    task automatic set_expected(input kind_sel_t kind, input alu_op_t op,
                                input logic [31:0] word, input logic [31:0] pc,
                                input logic sup);
        e_kind    = kind;
        e_op      = op;
        e_sup     = sup;
        e_pc      = pc;
        e_rd      = word[11:7];
        e_rs1     = (kind == K_LUI) ? 5'd0 : word[19:15];
        e_rs2     = word[24:20];
        e_funct3  = (word[1:0] == 2'b11) ? word[14:12] : `RV_FUNCT3_DEFAULT;
        chk_imm_i = 1'b0;
        chk_imm_j = 1'b0;
    endtask

    task automatic expect_imm_i(input logic [31:0] value);
        e_imm_i   = value;
        chk_imm_i = 1'b1;
    endtask

    task automatic expect_imm_j(input logic [31:0] value);
        e_imm_j   = value;
        chk_imm_j = 1'b1;
    endtask

    task automatic check_outputs();
        src_op1_t op1;
        src_op2_t op2;
        res_src_t res;
        logic     write;
        op1.pc      = e_kind inside {K_AUIPC, K_JAL};
        op1.r       = !op1.pc;
        op2.j       = (e_kind == K_JAL);
        op2.i       = e_kind inside {K_JALR, K_LOAD, K_IMM, K_LUI, K_AUIPC, K_STORE};
        op2.r       = !(op2.j || op2.i);
        res.memory  = (e_kind == K_LOAD);
        res.pc_next = e_kind inside {K_JAL, K_JALR};
        res.alu     = !(res.memory || res.pc_next);
        write       = e_kind inside {K_LOAD, K_IMM, K_REG, K_LUI, K_AUIPC, K_JAL, K_JALR};
        compare("o_pc", o_pc, e_pc);
        compare("o_pc_next", o_pc_next, e_pc + 32'd4);
        compare("o_rs1", 32'(o_rs1), 32'(e_rs1));
        compare("o_rs2", 32'(o_rs2), 32'(e_rs2));
        compare("o_rd", 32'(o_rd), 32'(e_rd));
        compare("o_funct3", 32'(o_funct3), 32'(e_funct3));
        compare("o_alu_res", 32'(o_alu_res), 32'(expected_res(e_op)));
        compare("o_alu_ctrl", 32'(o_alu_ctrl), 32'(expected_ctrl(e_op)));
        compare("o_op1_src", 32'(o_op1_src), 32'(op1));
        compare("o_op2_src", 32'(o_op2_src), 32'(op2));
        compare("o_res_src", 32'(o_res_src), 32'(res));
        compare("o_reg_write", 32'(o_reg_write), 32'(write));
        compare("o_inst_store", 32'(o_inst_store), 32'(e_kind == K_STORE));
        compare("o_inst_branch", 32'(o_inst_branch), 32'(e_kind == K_BRANCH));
        compare("o_inst_jal", 32'(o_inst_jal), 32'(e_kind == K_JAL));
        compare("o_inst_jalr", 32'(o_inst_jalr), 32'(e_kind == K_JALR));
        compare("o_inst_supported", 32'(o_inst_supported), 32'(e_sup));
        if (chk_imm_i)
            compare("o_imm_i", o_imm_i, e_imm_i);
        if (chk_imm_j)
            compare("o_imm_j", o_imm_j, e_imm_j);
    endtask

    task automatic reset_behavior();
        set_expected(K_NONE, ALU_NONE, '0, '0, 1'b1);
        expect_imm_i('0);
        expect_imm_j('0);
        check_outputs();
    endtask

    task automatic alu_operations();
        logic [31:0] word;
        logic [31:0] pc;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic        legal;
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int alt = 0; alt < 2; alt++)
            begin
                f7    = (alt == 1) ? `RV_FUNCT7_ALT : `RV_FUNCT7_BASE;
                pc    = rand_pc();
                word  = {f7, rand_reg(), rand_reg(), 3'(f3), rand_reg(), 7'b0110011};
                legal = (alt == 0) || (f3 == 0) || (f3 == 5);
                present(word, pc);
                if (legal)
                    set_expected(K_REG, op_for(3'(f3), alt == 1), word, pc, 1'b1);
                else
                    set_expected(K_NONE, ALU_NONE, word, pc, 1'b0);
                check_outputs();
                // shift immediates keep funct7 in the upper bits
                if (f3 == 1 || f3 == 5)
                    imm = {f7, rand_reg()};
                else
                    imm = 12'($urandom());
                pc    = rand_pc();
                word  = {imm, rand_reg(), 3'(f3), rand_reg(), 7'b0010011};
                legal = (f3 != 1) || (alt == 0);
                present(word, pc);
                if (legal)
                begin
                    set_expected(K_IMM, op_for(3'(f3), f3 == 5 && alt == 1), word, pc, 1'b1);
                    expect_imm_i({{20{imm[11]}}, imm});
                end
                else
                    set_expected(K_NONE, ALU_NONE, word, pc, 1'b0);
                check_outputs();
            end
        end
    endtask

    task automatic memory_and_upper();
        logic [31:0] word;
        logic [31:0] pc;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [2:0]  load_f3 [5];
        load_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        foreach (load_f3[n])
        begin
            imm  = 12'($urandom());
            pc   = rand_pc();
            word = {imm, rand_reg(), load_f3[n], rand_reg(), 7'b0000011};
            present(word, pc);
            set_expected(K_LOAD, ADD, word, pc, 1'b1);
            expect_imm_i({{20{imm[11]}}, imm});
            check_outputs();
        end
        for (int f3 = 0; f3 < 3; f3++)
        begin
            imm  = 12'($urandom());
            pc   = rand_pc();
            word = {imm[11:5], rand_reg(), rand_reg(), 3'(f3), imm[4:0], 7'b0100011};
            present(word, pc);
            set_expected(K_STORE, ADD, word, pc, 1'b1);
            expect_imm_i({{20{imm[11]}}, imm});
            check_outputs();
        end
        for (int n = 0; n < 4; n++)
        begin
            upper = 20'($urandom());
            pc    = rand_pc();
            word  = {upper, rand_reg(), (n < 2) ? 7'b0110111 : 7'b0010111};
            present(word, pc);
            set_expected((n < 2) ? K_LUI : K_AUIPC, ALU_NONE, word, pc, 1'b1);
            expect_imm_i({upper, 12'b0});
            check_outputs();
        end
    endtask

    task automatic branches_and_jumps();
        logic [31:0] word;
        logic [31:0] pc;
        logic [11:0] imm;
        logic [12:0] b_imm;
        logic [20:0] j_imm;
        alu_op_t     br_ops [6];
        logic [2:0]  br_f3 [6];
        br_ops = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        br_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        foreach (br_f3[n])
        begin
            b_imm = {12'($urandom()), 1'b0};
            pc    = rand_pc();
            word  = {b_imm[12], b_imm[10:5], rand_reg(), rand_reg(), br_f3[n],
                     b_imm[4:1], b_imm[11], 7'b1100011};
            present(word, pc);
            set_expected(K_BRANCH, br_ops[n], word, pc, 1'b1);
            expect_imm_j({{19{b_imm[12]}}, b_imm});
            check_outputs();
        end
        for (int n = 0; n < 3; n++)
        begin
            j_imm = {20'($urandom()), 1'b0};
            // last pass wraps the sequential pc
            pc    = (n == 2) ? 32'hffff_fffc : rand_pc();
            word  = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], rand_reg(), 7'b1101111};
            present(word, pc);
            set_expected(K_JAL, ALU_NONE, word, pc, 1'b1);
            expect_imm_j({{11{j_imm[20]}}, j_imm});
            check_outputs();
        end
        imm  = 12'($urandom());
        pc   = rand_pc();
        word = {imm, rand_reg(), 3'b000, rand_reg(), 7'b1100111};
        present(word, pc);
        set_expected(K_JALR, ALU_NONE, word, pc, 1'b1);
        expect_imm_i({{20{imm[11]}}, imm});
        check_outputs();
    endtask

    task automatic pipeline_control();
        logic [31:0] word;
        logic [31:0] held_pc;
        logic [31:0] pc;
        logic [11:0] imm;
        imm     = 12'($urandom());
        held_pc = rand_pc();
        word    = {imm, rand_reg(), 3'b000, rand_reg(), 7'b0010011};
        present(word, held_pc);
        set_expected(K_IMM, ADD, word, held_pc, 1'b1);
        expect_imm_i({{20{imm[11]}}, imm});
        check_outputs();
        // a new word under stall must not reach the outputs
        present({7'b0, rand_reg(), rand_reg(), 3'b000, rand_reg(), 7'b0110011},
                rand_pc(), 1'b1);
        check_outputs();
        // flush beats stall, pc stays where it was
        present(word, rand_pc(), 1'b1, 1'b1);
        set_expected(K_NONE, ALU_NONE, '0, held_pc, 1'b1);
        expect_imm_i('0);
        expect_imm_j('0);
        check_outputs();
        // nothing fetched, bubble at the new pc
        pc = rand_pc();
        present(word, pc, 1'b0, 1'b0, 1'b0);
        set_expected(K_NONE, ALU_NONE, '0, pc, 1'b1);
        expect_imm_i('0);
        expect_imm_j('0);
        check_outputs();
    endtask

    task automatic rejection();
        logic [31:0] words [5];
        logic [31:0] r;
        logic [31:0] pc;
        r        = $urandom();
        words[0] = {7'b0000001, rand_reg(), rand_reg(), 3'b000, rand_reg(), 7'b0110011};
        words[1] = 32'h0000_0073;
        words[2] = {12'($urandom()), rand_reg(), 3'b001, rand_reg(), 7'b1110011};
        words[3] = {r[31:2], 2'b01};
        words[4] = {r[31:2], 2'b10};
        foreach (words[n])
        begin
            pc = rand_pc();
            present(words[n], pc);
            set_expected(K_NONE, ALU_NONE, words[n], pc, 1'b0);
            check_outputs();
        end
    endtask

    initial
    begin
        #200us;
        $display("timeout: the test sequence did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

    initial
    begin
        void'($urandom(32'hc7bb));
        i_clk         = 1'b0;
        i_rst_n       = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b1;
        // live jump word and pc on the inputs all through reset
        i_instruction = {20'($urandom()), rand_reg(), 7'b1101111};
        i_pc          = rand_pc();
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        reset_behavior();
        alu_operations();
        memory_and_upper();
        branches_and_jumps();
        pipeline_control();
        rejection();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rv_decode_assert.sv
`default_nettype none

`include "rv_decode_defs.svh"

module rv_decode_assert
    import rv_decode_pkg::*;
(
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_stall,
    input  wire logic                 i_flush,
    input  wire logic [`RV_XLEN-1:0]  i_pc,
    input  wire logic [`RV_REG_W-1:0] i_rd,
    input  res_src_t                  i_res_src,
    input  src_op2_t                  i_op2_src,
    input  wire logic                 i_reg_write
);

    timeunit 1ns;
    timeprecision 1ps;

    a_res_src_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot(i_res_src))
        else $error("result source select is not one-hot");

    a_op2_src_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot(i_op2_src))
        else $error("second operand select is not one-hot");

    // flushed slot holds the zero word
    a_flush_no_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !i_reg_write)
        else $error("register write raised in the cycle after a flush");

    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_stall && !i_flush) |=> ($stable(i_pc) && $stable(i_rd)))
        else $error("pc or rd changed while the stage was stalled");

endmodule

bind rv_decode_top rv_decode_assert u_decode_assert
(
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_stall     (i_stall),
    .i_flush     (i_flush),
    .i_pc        (o_pc),
    .i_rd        (o_rd),
    .i_res_src   (o_res_src),
    .i_op2_src   (o_op2_src),
    .i_reg_write (o_reg_write)
);

`default_nettype wire

// File: logic/rv_decode_top.sv
`default_nettype none

`include "rv_decode_defs.svh"

module rv_decode_top
    import rv_decode_pkg::*;
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire logic                   i_stall,
    input  wire logic                   i_flush,
    input  wire logic                   i_ready,
    input  wire logic [`RV_INSTR_W-1:0] i_instruction,
    input  wire logic [`RV_XLEN-1:0]    i_pc,
    output logic [`RV_XLEN-1:0]         o_pc,
    output logic [`RV_XLEN-1:0]         o_pc_next,
    output logic [`RV_REG_W-1:0]        o_rs1,
    output logic [`RV_REG_W-1:0]        o_rs2,
    output logic [`RV_REG_W-1:0]        o_rd,
    output logic [`RV_XLEN-1:0]         o_imm_i,
    output logic [`RV_XLEN-1:0]         o_imm_j,
    output alu_res_t                    o_alu_res,
    output alu_ctrl_t                   o_alu_ctrl,
    output logic [`RV_FUNCT3_W-1:0]     o_funct3,
    output res_src_t                    o_res_src,
    output src_op1_t                    o_op1_src,
    output src_op2_t                    o_op2_src,
    output logic                        o_reg_write,
    output logic                        o_inst_jal,
    output logic                        o_inst_jalr,
    output logic                        o_inst_branch,
    output logic                        o_inst_store,
    output logic                        o_inst_supported
);

    stage_t      stage;
    instr_kind_t kind;
    alu_op_t     alu_op;

    decode_stage_reg u_stage_reg
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_ready        (i_ready),
        .i_instruction  (i_instruction),
        .i_pc           (i_pc),
        .o_stage        (stage)
    );

    instr_classifier u_classifier
    (
        .i_stage        (stage),
        .o_kind         (kind),
        .o_alu_op       (alu_op),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_rd           (o_rd),
        .o_funct3       (o_funct3),
        .o_op1_src      (o_op1_src),
        .o_op2_src      (o_op2_src),
        .o_res_src      (o_res_src),
        .o_reg_write    (o_reg_write),
        .o_supported    (o_inst_supported),
        .o_pc_next      (o_pc_next)
    );

    imm_gen u_imm_gen
    (
        .i_instruction  (stage.instruction),
        .i_kind         (kind),
        .o_imm_i        (o_imm_i),
        .o_imm_j        (o_imm_j)
    );

    alu_ctrl_gen u_alu_ctrl
    (
        .i_alu_op       (alu_op),
        .o_alu_res      (o_alu_res),
        .o_alu_ctrl     (o_alu_ctrl)
    );

    assign o_pc          = stage.pc;
    assign o_inst_jal    = kind.jal;
    assign o_inst_jalr   = kind.jalr;
    assign o_inst_branch = kind.branch;
    assign o_inst_store  = kind.store;

endmodule

`default_nettype wire

// File: logic/alu_ctrl_gen.sv
`default_nettype none

module alu_ctrl_gen
    import rv_decode_pkg::*;
(
    input  alu_op_t     i_alu_op,
    output alu_res_t    o_alu_res,
    output alu_ctrl_t   o_alu_ctrl
);

    alu_res_t  res;
    alu_ctrl_t ctrl;

    always_comb
    begin
        res  = '0;
        ctrl = '0;
        case (i_alu_op)
            ADD:
            begin
                res.arith      = 1'b1;
                ctrl.arith_add = 1'b1;
            end
            SUB:
            begin
                res.arith      = 1'b1;
                ctrl.arith_sub = 1'b1;
            end
            SLL:
            begin
                res.shift      = 1'b1;
                ctrl.arith_shl = 1'b1;
            end
            SRL, SRA:
            begin
                res.shift               = 1'b1;
                ctrl.arith_shr          = 1'b1;
                ctrl.shift_arithmetical = (i_alu_op == SRA);
            end
            AND:
            begin
                res.bits      = 1'b1;
                ctrl.bits_and = 1'b1;
            end
            OR:
            begin
                res.bits     = 1'b1;
                ctrl.bits_or = 1'b1;
            end
            XOR:
            begin
                res.bits      = 1'b1;
                ctrl.bits_xor = 1'b1;
            end
            // slt and branches share the comparator
            SLT, BLT, BGE:
            begin
                res.cmp           = 1'b1;
                ctrl.cmp_lts      = 1'b1;
                ctrl.cmp_inversed = (i_alu_op == BGE);
            end
            SLTU, BLTU, BGEU:
            begin
                res.cmp           = 1'b1;
                ctrl.cmp_ltu      = 1'b1;
                ctrl.cmp_inversed = (i_alu_op == BGEU);
            end
            BEQ, BNE:
            begin
                res.cmp           = 1'b1;
                ctrl.cmp_eq       = 1'b1;
                ctrl.cmp_inversed = (i_alu_op == BNE);
            end
            default:
            begin
                res  = '0;
                ctrl = '0;
            end
        endcase
    end

    assign o_alu_res  = res;
    assign o_alu_ctrl = ctrl;

endmodule

`default_nettype wire

// File: logic/imm_gen.sv
`default_nettype none

`include "rv_decode_defs.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  wire logic [`RV_INSTR_W-1:0] i_instruction,
    input  instr_kind_t                 i_kind,
    output logic [`RV_XLEN-1:0]         o_imm_i,
    output logic [`RV_XLEN-1:0]         o_imm_j
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic                sign;

    // bit 31 is the sign in every format
    assign sign = i_instruction[31];

    assign imm_i = {{21{sign}}, i_instruction[30:20]};
    assign imm_s = {{21{sign}}, i_instruction[30:25], i_instruction[11:7]};

    // branch and jump offsets are halfword aligned
    assign imm_b = {{20{sign}}, i_instruction[7], i_instruction[30:25],
                    i_instruction[11:8], 1'b0};
    assign imm_j = {{12{sign}}, i_instruction[19:12], i_instruction[20],
                    i_instruction[30:21], 1'b0};

    assign imm_u = {i_instruction[31:12], 12'b0};

    always_comb
    begin
        if (i_kind.lui || i_kind.auipc)
            o_imm_i = imm_u;
        else if (i_kind.store)
            o_imm_i = imm_s;
        else
            o_imm_i = imm_i;
    end

    assign o_imm_j = i_kind.jal ? imm_j : imm_b;

endmodule

`default_nettype wire

// File: logic/instr_classifier.sv
`default_nettype none

`include "rv_decode_defs.svh"

module instr_classifier
    import rv_decode_pkg::*;
(
    input  stage_t                      i_stage,
    output instr_kind_t                 o_kind,
    output alu_op_t                     o_alu_op,
    output logic [`RV_REG_W-1:0]        o_rs1,
    output logic [`RV_REG_W-1:0]        o_rs2,
    output logic [`RV_REG_W-1:0]        o_rd,
    output logic [`RV_FUNCT3_W-1:0]     o_funct3,
    output src_op1_t                    o_op1_src,
    output src_op2_t                    o_op2_src,
    output res_src_t                    o_res_src,
    output logic                        o_reg_write,
    output logic                        o_supported,
    output logic [`RV_XLEN-1:0]         o_pc_next
);

    logic [`RV_INSTR_W-1:0]     instr;
    opc_t                       opc;
    logic [`RV_FUNCT3_W-1:0]    funct3;
    logic [6:0]                 funct7;
    logic                       full;
    logic                       f7_base;
    logic                       f7_alt;
    logic                       legal;
    logic                       valid;
    alu_op_t                    op_raw;
    instr_kind_t                kind_raw;
    instr_kind_t                kind;

    // shared by the register and immediate forms
    function automatic alu_op_t arith_op(input logic [`RV_FUNCT3_W-1:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? SUB : ADD;
            3'b001:  arith_op = SLL;
            3'b010:  arith_op = SLT;
            3'b011:  arith_op = SLTU;
            3'b100:  arith_op = XOR;
            3'b101:  arith_op = alt ? SRA : SRL;
            3'b110:  arith_op = OR;
            default: arith_op = AND;
        endcase
    endfunction

    assign instr   = i_stage.instruction;
    assign opc     = opc_t'(instr[6:2]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign full    = (instr[1:0] == 2'b11);
    assign f7_base = (funct7 == `RV_FUNCT7_BASE);
    assign f7_alt  = (funct7 == `RV_FUNCT7_ALT);

    always_comb
    begin
        legal    = 1'b0;
        op_raw   = ALU_NONE;
        kind_raw = '0;
        case (opc)
            LD:
            begin
                // lb lh lw lbu lhu
                legal         = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
                op_raw        = ADD;
                kind_raw.load = 1'b1;
            end
            STR:
            begin
                legal          = (funct3 < 3'b011);
                op_raw         = ADD;
                kind_raw.store = 1'b1;
            end
            ARI:
            begin
                // only the shifts carry funct7, the rest is immediate
                if (funct3 == 3'b001)
                    legal = f7_base;
                else if (funct3 == 3'b101)
                    legal = f7_base || f7_alt;
                else
                    legal = 1'b1;
                op_raw       = arith_op(funct3, (funct3 == 3'b101) && f7_alt);
                kind_raw.imm = 1'b1;
            end
            ARR:
            begin
                legal           = f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
                op_raw          = arith_op(funct3, f7_alt);
                kind_raw.reg_op = 1'b1;
            end
            LUI:
            begin
                legal        = 1'b1;
                kind_raw.lui = 1'b1;
            end
            AUI:
            begin
                legal          = 1'b1;
                kind_raw.auipc = 1'b1;
            end
            B:
            begin
                legal           = (funct3[2:1] != 2'b01);
                op_raw          = funct3[2] ? (funct3[1] ? (funct3[0] ? BGEU : BLTU)
                                                        : (funct3[0] ? BGE : BLT))
                                            : (funct3[0] ? BNE : BEQ);
                kind_raw.branch = 1'b1;
            end
            JAL:
            begin
                legal        = 1'b1;
                kind_raw.jal = 1'b1;
            end
            JALR:
            begin
                legal         = (funct3 == 3'b000);
                kind_raw.jalr = 1'b1;
            end
            // system and fence words are rejected
            SYS, MEM:
                legal = 1'b0;
            default:
                legal = 1'b0;
        endcase
    end

    assign valid    = full && legal;
    assign kind     = valid ? kind_raw : '0;
    assign o_kind   = kind;
    assign o_alu_op = valid ? op_raw : ALU_NONE;

    // the all-zero word is a bubble and still counts as supported
    assign o_supported = valid || (instr == '0);

    assign o_rd     = instr[11:7];
    assign o_rs1    = kind.lui ? '0 : instr[19:15];
    assign o_rs2    = instr[24:20];
    assign o_funct3 = full ? funct3 : `RV_FUNCT3_DEFAULT;

    assign o_op1_src.pc = kind.auipc || kind.jal;
    assign o_op1_src.r  = !(kind.auipc || kind.jal);

    assign o_op2_src.j = kind.jal;
    assign o_op2_src.i = kind.jalr || kind.load || kind.imm || kind.lui
                      || kind.auipc || kind.store;
    assign o_op2_src.r = !(o_op2_src.j || o_op2_src.i);

    assign o_res_src.memory  = kind.load;
    assign o_res_src.pc_next = kind.jal || kind.jalr;
    assign o_res_src.alu     = !(kind.load || kind.jal || kind.jalr);

    assign o_reg_write = kind.load || kind.imm || kind.reg_op || kind.lui
                      || kind.auipc || kind.jal || kind.jalr;

    assign o_pc_next = i_stage.pc + `RV_XLEN'(`RV_PC_STEP);

endmodule

`default_nettype wire

// File: logic/decode_stage_reg.sv
`default_nettype none

`include "rv_decode_defs.svh"

module decode_stage_reg
    import rv_decode_pkg::*;
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire logic                   i_stall,
    input  wire logic                   i_flush,
    input  wire logic                   i_ready,
    input  wire logic [`RV_INSTR_W-1:0] i_instruction,
    input  wire logic [`RV_XLEN-1:0]    i_pc,
    output stage_t                      o_stage
);

    stage_t stage;

    // reset, then flush, then stall, then capture
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            stage.instruction <= '0;
            stage.pc          <= '0;
        end
        else if (i_flush)
        begin
            // zero word decodes as a harmless bubble
            stage.instruction <= '0;
        end
        else if (!i_stall)
        begin
            // nothing fetched yet, so insert a bubble
            stage.instruction <= i_ready ? i_instruction : '0;
            stage.pc          <= i_pc;
        end
    end

    assign o_stage = stage;

endmodule

`default_nettype wire

// File: logic/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_defs.svh"

package rv_decode_pkg;

    // major opcode, bits [6:2] of the word
    typedef enum logic [4:0]
    {
        LD   = 5'b00000,
        MEM  = 5'b00011,
        ARI  = 5'b00100,
        AUI  = 5'b00101,
        STR  = 5'b01000,
        ARR  = 5'b01100,
        LUI  = 5'b01101,
        B    = 5'b11000,
        JALR = 5'b11001,
        JAL  = 5'b11011,
        SYS  = 5'b11100
    } opc_t;

    // decoded ALU operation
    typedef enum logic [4:0]
    {
        ALU_NONE,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } alu_op_t;

    typedef struct packed
    {
        logic [`RV_INSTR_W-1:0] instruction;
        logic [`RV_XLEN-1:0]    pc;
    } stage_t;

    // one hot, or all zero when unsupported
    typedef struct packed
    {
        logic load;
        logic store;
        logic imm;
        logic reg_op;
        logic lui;
        logic auipc;
        logic branch;
        logic jal;
        logic jalr;
    } instr_kind_t;

    typedef struct packed
    {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_res_t;

    typedef struct packed
    {
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_shl;
        logic arith_shr;
        logic arith_sub;
        logic arith_add;
        logic shift_arithmetical;
    } alu_ctrl_t;

    typedef struct packed
    {
        logic r;
        logic pc;
    } src_op1_t;

    typedef struct packed
    {
        logic r;
        logic i;
        logic j;
    } src_op2_t;

    typedef struct packed
    {
        logic alu;
        logic memory;
        logic pc_next;
    } res_src_t;

endpackage

`default_nettype wire

// File: logic/rv_decode_defs.svh
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// data path and program counter width
`define RV_XLEN             32

// fetched word width, compressed encodings not handled
`define RV_INSTR_W          32

// register file index width
`define RV_REG_W            5

// minor opcode field width
`define RV_FUNCT3_W         3

// sequential step, always a full word
`define RV_PC_STEP          4

// funct7 for the plain operation
`define RV_FUNCT7_BASE      7'b0000000

// funct7 selecting sub and sra
`define RV_FUNCT7_ALT       7'b0100000

// word size, shown on funct3 when the low bits are not 2'b11
`define RV_FUNCT3_DEFAULT   3'b010

`endif
